/* all.f */
+incdir+include
verilog/csa_pkg.sv
verilog/csa_feed.sv
verilog/csa_round_stage.sv
verilog/csa_retire.sv
verilog/csa_calc_top.sv
verif/csa_calc_tb.sv

/* include/csa_params.svh */
`ifndef CSA_PARAMS_SVH
`define CSA_PARAMS_SVH

// field widths
`define CSA_WORD_W 32
`define CSA_IN_W 48
`define CSA_STATE_W 64

// ring stages, one round each
`define CSA_PIPE_DEPTH 8
`define CSA_ROUND_ROT 8

// fixed sbox input of the cipher core
`define CSA_SB_CONST 64'hE613DB6DC11C4524

`endif

/* run.sh */
#!/bin/sh
# build and run the ring testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module csa_calc_tb -Mdir obj_dir -f all.f

result=$(./obj_dir/Vcsa_calc_tb 2>&1) || true
printf '%s\n' "$result"

# the run counts as passed only if the pass line shows up
printf '%s\n' "$result" | grep -q "Simulation PASSED"

/* verif/csa_calc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csa_params.svh"

module csa_calc_tb;
	import csa_pkg::*;

	localparam int NUM_REC = 16;
	localparam int REC_WORDS = 5; // block, in, times, start, passes

	logic clk;
	logic rst_n;
	logic fifo_ready_i;
	word_t fifo_block_i;
	in_t fifo_in_i;
	word_t fifo_times_i;
	word_t fifo_start_i;
	wire fifo_ren_o;
	wire ready_o;
	word_t block_o;
	in_t in_o;
	word_t times_o;
	word_t start_o;
	state_t out_o;

	logic [63:0] rec_mem [0:NUM_REC*REC_WORDS-1];
	word_t rec_block [NUM_REC];
	in_t rec_in [NUM_REC];
	word_t rec_times [NUM_REC];
	word_t rec_start [NUM_REC];
	word_t rec_passes [NUM_REC];
	state_t rec_exp [NUM_REC];
	word_t pop_cyc [NUM_REC];
	bit seen [NUM_REC];

	int expect_count = 0;
	int sum_passes = 0;
	int limit_ns = 0;
	int pop_count = 0;
	int retired_count = 0;
	int last_idx = -1;
	bit ooo_seen = 1'b0;
	bit running = 1'b0;
	word_t cyc = '0;
	logic [31:0] rnd = 32'h766d_6a7f;

	csa_calc_top u_csa_calc_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.fifo_ready_i (fifo_ready_i),
		.fifo_block_i (fifo_block_i),
		.fifo_in_i    (fifo_in_i),
		.fifo_times_i (fifo_times_i),
		.fifo_start_i (fifo_start_i),
		.fifo_ren_o   (fifo_ren_o),
		.ready_o      (ready_o),
		.block_o      (block_o),
		.in_o         (in_o),
		.times_o      (times_o),
		.start_o      (start_o),
		.out_o        (out_o)
	);

	always #5 clk = ~clk;

	always @(posedge clk) cyc <= cyc + word_t'(1); // edge count

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// xor with the sbox word, then rotate left
	function automatic state_t ref_round(input state_t s);
		state_t x;
		x = s ^ `CSA_SB_CONST;
		return {x[`CSA_STATE_W-`CSA_ROUND_ROT-1:0], x[`CSA_STATE_W-1:`CSA_STATE_W-`CSA_ROUND_ROT]};
	endfunction

	function automatic state_t apply_rounds(input in_t w, input int n);
		state_t s;
		s = {{(`CSA_STATE_W-`CSA_IN_W){1'b0}}, w};
		for (int k = 0; k < n; k++) begin
			s = ref_round(s);
		end
		return s;
	endfunction

	function automatic int find_record(input word_t tag);
		int idx;
		idx = -1;
		for (int k = 0; k < NUM_REC; k++) begin
			if (rec_block[k] == tag && rec_passes[k] != '0)
				idx = k;
		end
		return idx;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_in(input string name, input in_t got, input in_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_state(input string name, input state_t got, input state_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	task automatic load_records;
		int i;
		word_t rule_passes;
		$readmemh("verif/csa_input.txt", rec_mem);
		for (i = 0; i < NUM_REC; i++) begin
			rec_block[i] = rec_mem[i*REC_WORDS][31:0];
			rec_in[i] = rec_mem[i*REC_WORDS+1][`CSA_IN_W-1:0];
			rec_times[i] = rec_mem[i*REC_WORDS+2][31:0];
			rec_start[i] = rec_mem[i*REC_WORDS+3][31:0];
			rec_passes[i] = rec_mem[i*REC_WORDS+4][31:0];
			seen[i] = 1'b0;
			pop_cyc[i] = '0;
			// zero times means popped and dropped
			rule_passes = (rec_times[i] == '0) ? '0 : rec_times[i] - rec_start[i] + word_t'(1);
			check_word($sformatf("record %0d pass count", i), rec_passes[i], rule_passes);
			rec_exp[i] = apply_rounds(rec_in[i], int'(rec_passes[i]) * `CSA_PIPE_DEPTH);
			if (rec_passes[i] != '0)
				expect_count = expect_count + 1;
			sum_passes = sum_passes + int'(rec_passes[i]);
		end
		limit_ns = sum_passes * `CSA_PIPE_DEPTH * 10 + 200 * 10;
	endtask

	task automatic check_result;
		int idx;
		idx = find_record(block_o);
		if (idx < 0) begin
			abort_run($sformatf("ready_o pulsed for block %h with no pending job", block_o));
		end else if (seen[idx]) begin
			abort_run($sformatf("block %h was reported twice", block_o));
		end else if (idx >= pop_count) begin
			abort_run($sformatf("block %h retired before it was popped", block_o));
		end else begin
			seen[idx] = 1'b1;
			check_in("in_o", in_o, rec_in[idx]);
			check_word("times_o", times_o, rec_times[idx]);
			check_word("start_o", start_o, rec_start[idx]);
			check_state("out_o", out_o, rec_exp[idx]);
			check_word("ready_o cycle", cyc,
				pop_cyc[idx] + rec_passes[idx] * word_t'(`CSA_PIPE_DEPTH));
			if (idx < last_idx)
				ooo_seen = 1'b1; // overtook an older job
			last_idx = idx;
			retired_count = retired_count + 1;
		end
	endtask

	// show-ahead FIFO model, head record always on the inputs
	always @(posedge clk) begin
		if (running) begin
			rnd = xorshift32(rnd);
			fifo_ready_i <= (pop_count < NUM_REC) && (rnd[1:0] != 2'b00);
			if (pop_count < NUM_REC) begin
				fifo_block_i <= rec_block[pop_count];
				fifo_in_i <= rec_in[pop_count];
				fifo_times_i <= rec_times[pop_count];
				fifo_start_i <= rec_start[pop_count];
			end
		end
	end

	// mid-cycle monitor, pop takes effect at the next rising edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (fifo_ren_o && !fifo_ready_i)
				abort_run("fifo_ren_o was high while fifo_ready_i was low");
			if (fifo_ren_o) begin
				pop_cyc[pop_count] = cyc + word_t'(1);
				pop_count = pop_count + 1;
			end
			if (ready_o)
				check_result();
		end
	end

	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		abort_run($sformatf("watchdog expired after %0d ns before all jobs retired", limit_ns));
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		fifo_ready_i = 1'b0;
		fifo_block_i = '0;
		fifo_in_i = '0;
		fifo_times_i = '0;
		fifo_start_i = '0;
		load_records();

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		check_word("block_o", block_o, '0);
		check_in("in_o", in_o, '0);
		check_word("times_o", times_o, '0);
		check_word("start_o", start_o, '0);
		check_state("out_o", out_o, '0);

		// idle ring stays quiet
		repeat (10) begin
			@(negedge clk);
			if (ready_o || fifo_ren_o)
				abort_run("ready_o or fifo_ren_o rose with no record offered");
		end
		running = 1'b1;

		while (!(pop_count == NUM_REC && retired_count == expect_count))
			@(posedge clk);
		repeat (4 * `CSA_PIPE_DEPTH) @(posedge clk); // stray pulses caught by monitor

		if (ooo_seen) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			abort_run("no job retired ahead of a record popped before it");
		end
	end

endmodule

`default_nettype wire

/* verif/csa_input.txt */
// columns: block (32b) input word (48b) times (32b) start (32b) expected passes (32b)
// expected passes is times-start+1, or 0 for a record with times of zero
00000011 0000deadbeef 00000001 00000001 00000001
00000012 123456789abc 00000005 00000005 00000001
00000021 00000000a5a5 00000004 00000001 00000004
00000022 fedcba987654 00000006 00000002 00000005
00000030 000000000000 00000000 00000000 00000000
00000041 111122223333 00000007 00000002 00000006
00000042 444455556666 00000002 00000002 00000001
00000043 777788889999 00000003 00000002 00000002
00000044 aaaabbbbcccc 00000001 00000001 00000001
00000031 0000ffff0000 00000000 00000003 00000000
00000045 0123456789ab 00000009 00000006 00000004
00000046 cdef01234567 00000003 00000000 00000004
00000047 000000000001 00000002 00000001 00000002
00000048 800000000000 00000004 00000004 00000001
00000049 5a5a5a5a5a5a 00000008 00000003 00000006
0000004a 0f0f0f0f0f0f 00000001 00000001 00000001

/* verilog/csa_calc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csa_params.svh"

module csa_calc_top (
	input wire clk,
	input wire rst_n,

	input wire fifo_ready_i,
	input wire csa_pkg::word_t fifo_block_i,
	input wire csa_pkg::in_t fifo_in_i,
	input wire csa_pkg::word_t fifo_times_i,
	input wire csa_pkg::word_t fifo_start_i,
	output wire fifo_ren_o,

	output wire ready_o,
	output wire csa_pkg::word_t block_o,
	output wire csa_pkg::in_t in_o,
	output wire csa_pkg::word_t times_o,
	output wire csa_pkg::word_t start_o,
	output wire csa_pkg::state_t out_o
);
	import csa_pkg::*;

	// feed output into the first stage
	logic fd_valid;
	word_t fd_block;
	in_t fd_in;
	word_t fd_times;
	word_t fd_start;
	word_t fd_left;
	state_t fd_state;

	// ring links, index k is the output of stage k
	logic lk_valid [1:`CSA_PIPE_DEPTH];
	word_t lk_block [1:`CSA_PIPE_DEPTH];
	in_t lk_in [1:`CSA_PIPE_DEPTH];
	word_t lk_times [1:`CSA_PIPE_DEPTH];
	word_t lk_start [1:`CSA_PIPE_DEPTH];
	word_t lk_left [1:`CSA_PIPE_DEPTH];
	state_t lk_state [1:`CSA_PIPE_DEPTH];

	// recirculation back to the entry
	logic rc_valid;
	word_t rc_block;
	in_t rc_in;
	word_t rc_times;
	word_t rc_start;
	word_t rc_left;
	state_t rc_state;

	csa_feed u_csa_feed (
		.fifo_ready_i (fifo_ready_i),
		.fifo_block_i (fifo_block_i),
		.fifo_in_i    (fifo_in_i),
		.fifo_times_i (fifo_times_i),
		.fifo_start_i (fifo_start_i),
		.fifo_ren_o   (fifo_ren_o),
		.rc_valid_i   (rc_valid),
		.rc_block_i   (rc_block),
		.rc_in_i      (rc_in),
		.rc_times_i   (rc_times),
		.rc_start_i   (rc_start),
		.rc_left_i    (rc_left),
		.rc_state_i   (rc_state),
		.out_valid_o  (fd_valid),
		.out_block_o  (fd_block),
		.out_in_o     (fd_in),
		.out_times_o  (fd_times),
		.out_start_o  (fd_start),
		.out_left_o   (fd_left),
		.out_state_o  (fd_state)
	);

	for (genvar g = 0; g < `CSA_PIPE_DEPTH; g++) begin : g_stage
		logic s_valid;
		word_t s_block;
		in_t s_in;
		word_t s_times;
		word_t s_start;
		word_t s_left;
		state_t s_state;

		if (g == 0) begin : g_first
			assign s_valid = fd_valid;
			assign s_block = fd_block;
			assign s_in = fd_in;
			assign s_times = fd_times;
			assign s_start = fd_start;
			assign s_left = fd_left;
			assign s_state = fd_state;
		end else begin : g_next
			assign s_valid = lk_valid[g];
			assign s_block = lk_block[g];
			assign s_in = lk_in[g];
			assign s_times = lk_times[g];
			assign s_start = lk_start[g];
			assign s_left = lk_left[g];
			assign s_state = lk_state[g];
		end

		csa_round_stage u_stage (
			.clk         (clk),
			.rst_n       (rst_n),
			.in_valid_i  (s_valid),
			.in_block_i  (s_block),
			.in_in_i     (s_in),
			.in_times_i  (s_times),
			.in_start_i  (s_start),
			.in_left_i   (s_left),
			.in_state_i  (s_state),
			.out_valid_o (lk_valid[g+1]),
			.out_block_o (lk_block[g+1]),
			.out_in_o    (lk_in[g+1]),
			.out_times_o (lk_times[g+1]),
			.out_start_o (lk_start[g+1]),
			.out_left_o  (lk_left[g+1]),
			.out_state_o (lk_state[g+1])
		);
	end

	csa_retire u_csa_retire (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid_i (lk_valid[`CSA_PIPE_DEPTH]),
		.in_block_i (lk_block[`CSA_PIPE_DEPTH]),
		.in_in_i    (lk_in[`CSA_PIPE_DEPTH]),
		.in_times_i (lk_times[`CSA_PIPE_DEPTH]),
		.in_start_i (lk_start[`CSA_PIPE_DEPTH]),
		.in_left_i  (lk_left[`CSA_PIPE_DEPTH]),
		.in_state_i (lk_state[`CSA_PIPE_DEPTH]),
		.rc_valid_o (rc_valid),
		.rc_block_o (rc_block),
		.rc_in_o    (rc_in),
		.rc_times_o (rc_times),
		.rc_start_o (rc_start),
		.rc_left_o  (rc_left),
		.rc_state_o (rc_state),
		.ready_o    (ready_o),
		.block_o    (block_o),
		.in_o       (in_o),
		.times_o    (times_o),
		.start_o    (start_o),
		.out_o      (out_o)
	);

endmodule

`default_nettype wire

/* verilog/csa_feed.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_feed (
	input wire fifo_ready_i,
	input wire csa_pkg::word_t fifo_block_i,
	input wire csa_pkg::in_t fifo_in_i,
	input wire csa_pkg::word_t fifo_times_i,
	input wire csa_pkg::word_t fifo_start_i,
	output logic fifo_ren_o,

	input wire rc_valid_i,
	input wire csa_pkg::word_t rc_block_i,
	input wire csa_pkg::in_t rc_in_i,
	input wire csa_pkg::word_t rc_times_i,
	input wire csa_pkg::word_t rc_start_i,
	input wire csa_pkg::word_t rc_left_i,
	input wire csa_pkg::state_t rc_state_i,

	output logic out_valid_o,
	output csa_pkg::word_t out_block_o,
	output csa_pkg::in_t out_in_o,
	output csa_pkg::word_t out_times_o,
	output csa_pkg::word_t out_start_o,
	output csa_pkg::word_t out_left_o,
	output csa_pkg::state_t out_state_o
);
	import csa_pkg::*;

	state_t seed;

	// input word zero-extended into the cipher state
	assign seed = state_t'(fifo_in_i);

	// pop only when the arriving slot is free
	assign fifo_ren_o = fifo_ready_i & ~rc_valid_i;

	always_comb begin
		if (rc_valid_i) begin // job going around again
			out_valid_o = 1'b1;
			out_block_o = rc_block_i;
			out_in_o = rc_in_i;
			out_times_o = rc_times_i;
			out_start_o = rc_start_i;
			out_left_o = rc_left_i;
			out_state_o = rc_state_i;
		end else begin
			// times of zero is popped and dropped
			out_valid_o = fifo_ren_o && (fifo_times_i != '0);
			out_block_o = fifo_block_i;
			out_in_o = fifo_in_i;
			out_times_o = fifo_times_i;
			out_start_o = fifo_start_i;
			out_left_o = fifo_times_i - fifo_start_i; // passes left
			out_state_o = seed;
		end
	end

endmodule

`default_nettype wire

/* verilog/csa_pkg.sv */
`default_nettype none

package csa_pkg;

`include "csa_params.svh"

	typedef logic [`CSA_WORD_W-1:0] word_t; // block tag, times, counts
	typedef logic [`CSA_IN_W-1:0] in_t;
	typedef logic [`CSA_STATE_W-1:0] state_t;

	// stand-in round: xor with sbox constant, then rotate left
	function automatic state_t csa_round(input state_t s);
		state_t x;
		x = s ^ `CSA_SB_CONST;
		return (x << `CSA_ROUND_ROT) | (x >> (`CSA_STATE_W - `CSA_ROUND_ROT));
	endfunction

endpackage

`default_nettype wire

/* verilog/csa_retire.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_retire (
	input wire clk,
	input wire rst_n,

	input wire in_valid_i,
	input wire csa_pkg::word_t in_block_i,
	input wire csa_pkg::in_t in_in_i,
	input wire csa_pkg::word_t in_times_i,
	input wire csa_pkg::word_t in_start_i,
	input wire csa_pkg::word_t in_left_i,
	input wire csa_pkg::state_t in_state_i,

	output logic rc_valid_o,
	output csa_pkg::word_t rc_block_o,
	output csa_pkg::in_t rc_in_o,
	output csa_pkg::word_t rc_times_o,
	output csa_pkg::word_t rc_start_o,
	output csa_pkg::word_t rc_left_o,
	output csa_pkg::state_t rc_state_o,

	output logic ready_o,
	output csa_pkg::word_t block_o,
	output csa_pkg::in_t in_o,
	output csa_pkg::word_t times_o,
	output csa_pkg::word_t start_o,
	output csa_pkg::state_t out_o
);
	import csa_pkg::*;

	logic done;
	word_t left_dec;

	assign done = in_valid_i && (in_left_i == '0); // last pass finished
	assign left_dec = in_left_i - word_t'(1);

	// recirculation link, combinational so a pass stays DEPTH cycles
	assign rc_valid_o = in_valid_i && !done;
	assign rc_block_o = in_block_i;
	assign rc_in_o = in_in_i;
	assign rc_times_o = in_times_i;
	assign rc_start_o = in_start_i;
	assign rc_left_o = left_dec;
	assign rc_state_o = in_state_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ready_o <= 1'b0;
			block_o <= '0;
			in_o <= '0;
			times_o <= '0;
			start_o <= '0;
			out_o <= '0;
		end else begin
			ready_o <= done; // single cycle pulse
			// results hold until the next retirement
			if (done) begin
				block_o <= in_block_i;
				in_o <= in_in_i;
				times_o <= in_times_i;
				start_o <= in_start_i;
				out_o <= in_state_i;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/csa_round_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_round_stage (
	input wire clk,
	input wire rst_n,

	input wire in_valid_i,
	input wire csa_pkg::word_t in_block_i,
	input wire csa_pkg::in_t in_in_i,
	input wire csa_pkg::word_t in_times_i,
	input wire csa_pkg::word_t in_start_i,
	input wire csa_pkg::word_t in_left_i,
	input wire csa_pkg::state_t in_state_i,

	output logic out_valid_o,
	output csa_pkg::word_t out_block_o,
	output csa_pkg::in_t out_in_o,
	output csa_pkg::word_t out_times_o,
	output csa_pkg::word_t out_start_o,
	output csa_pkg::word_t out_left_o,
	output csa_pkg::state_t out_state_o
);
	import csa_pkg::*;

	state_t next_state;

	assign next_state = csa_round(in_state_i);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid_o <= 1'b0;
			out_block_o <= '0;
			out_in_o <= '0;
			out_times_o <= '0;
			out_start_o <= '0;
			out_left_o <= '0;
			out_state_o <= '0;
		end else begin
			out_valid_o <= in_valid_i; // empty slots travel too
			out_block_o <= in_block_i;
			out_in_o <= in_in_i;
			out_times_o <= in_times_i;
			out_start_o <= in_start_i;
			out_left_o <= in_left_i;
			// one round per stage
			out_state_o <= next_state;
		end
	end

endmodule

`default_nettype wire
